// File: common/rv_pkg.sv
package rv_pkg;

	// ####################
	// Basic types
	// ####################

	typedef logic [31:0] word_t;     // Data or address word.
	typedef logic [3:0]  reg_addr_t; // RV32E register index.
	typedef logic [3:0]  strb_t;     // Byte write strobe.

	// Major opcodes used by the supported subset.
	typedef enum logic [6:0] {
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_system = 7'b1110011
	} opcode_t;

	typedef enum logic [3:0] {
		op_alu_imm,
		op_alu_reg,
		op_lui,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_halt,
		op_illegal
	} op_kind_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		strb_t wstrb;
		logic  write;
	} bus_req_t;

	// ####################
	// Unit state machines
	// ####################

	typedef enum logic {fetch_idle, fetch_wait} fetch_state_t;

	typedef enum logic [1:0] {exec_idle, exec_run, exec_mem, exec_halt} exec_state_t;

	typedef enum logic [1:0] {lsu_idle, lsu_issue, lsu_wait} lsu_state_t;

	localparam word_t clint_base = 32'h0200_bff8; // Low word of mtime.
	localparam word_t reset_pc   = 32'h0000_0000;

endpackage

// File: core/rv_regfile.sv
module rv_regfile #(
	parameter int num_regs = 16
) (
	input  logic              clock,
	input  logic              rst,
	input  rv_pkg::reg_addr_t raddr1,
	input  rv_pkg::reg_addr_t raddr2,
	output rv_pkg::word_t     rdata1,
	output rv_pkg::word_t     rdata2,
	input  logic              wen,
	input  rv_pkg::reg_addr_t waddr,
	input  rv_pkg::word_t     wdata
);
	import rv_pkg::*;

	word_t regs [num_regs];

	logic write_ok;

	// x0 is never written, so it reads back the reset value.
	assign write_ok = wen && (waddr != '0) && (int'(waddr) < num_regs);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (write_ok) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1]; // Combinational read.
	assign rdata2 = regs[raddr2];

endmodule

// File: core/rv_fetch.sv
module rv_fetch (
	input  logic          clock,
	input  logic          rst,
	input  logic          retire,
	input  rv_pkg::word_t next_pc,
	input  logic          halted,
	output logic          fetch_req_valid,
	output rv_pkg::word_t fetch_addr,
	input  logic          fetch_resp_valid,
	input  rv_pkg::word_t fetch_data,
	output logic          inst_valid,
	output rv_pkg::word_t inst,
	output rv_pkg::word_t pc
);
	import rv_pkg::*;

	fetch_state_t state;
	logic         boot_q;

	// First fetch goes out as soon as reset is released.
	assign fetch_req_valid = !halted && (retire || (boot_q && !rst));
	assign fetch_addr      = retire ? next_pc : pc;

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= fetch_idle;
			boot_q     <= 1'b1;
			pc         <= reset_pc;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				fetch_idle: if (fetch_req_valid) begin
					state  <= fetch_wait;
					boot_q <= 1'b0;
					pc     <= fetch_addr; // PC of the instruction in flight.
				end
				fetch_wait: if (fetch_resp_valid) begin
					state      <= fetch_idle;
					inst_valid <= 1'b1;
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == fetch_wait && fetch_resp_valid) inst <= fetch_data;
	end

	// ####################
	// Checks
	// ####################

	a_no_req_in_wait: assert property (@(posedge clock) disable iff (rst)
		state == fetch_wait |-> !fetch_req_valid);

endmodule

// File: core/rv_execute.sv
module rv_execute (
	input  logic               clock,
	input  logic               rst,
	input  logic               inst_valid,
	input  rv_pkg::word_t      inst,
	input  rv_pkg::word_t      pc,
	output rv_pkg::reg_addr_t  rs1,
	output rv_pkg::reg_addr_t  rs2,
	input  rv_pkg::word_t      rs1_data,
	input  rv_pkg::word_t      rs2_data,
	output logic               reg_wen,
	output rv_pkg::reg_addr_t  rd,
	output rv_pkg::word_t      wb_data,
	output logic               mem_start,
	output rv_pkg::bus_req_t   mem_op,
	input  logic               mem_done,
	input  rv_pkg::word_t      load_data,
	output logic               retire,
	output rv_pkg::word_t      next_pc,
	output logic               halted
);
	import rv_pkg::*;

	exec_state_t state;
	word_t       inst_q;
	word_t       pc_q;
	op_kind_t    kind;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic        alu_f3_ok;
	word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t       alu_b;
	word_t       alu_out;
	word_t       pc_plus4;
	logic        take_branch;
	logic        run;
	logic        is_mem;

	assign funct3 = inst_q[14:12];
	assign funct7 = inst_q[31:25];
	assign rs1    = inst_q[18:15];
	assign rs2    = inst_q[23:20];
	assign rd     = inst_q[10:7];

	assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
	assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
	assign imm_u = {inst_q[31:12], 12'b0};
	assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

	assign alu_f3_ok = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

	// ####################
	// Decode
	// ####################

	// Register numbers above x15 do not exist in RV32E.
	always_comb begin
		kind = op_illegal;
		case (inst_q[6:0])
			opc_op_imm: if (alu_f3_ok && !inst_q[11] && !inst_q[19]) kind = op_alu_imm;
			opc_op: if (!inst_q[11] && !inst_q[19] && !inst_q[24] &&
					((funct7 == 7'b0000000 && alu_f3_ok) ||
					(funct7 == 7'b0100000 && funct3 == 3'b000))) kind = op_alu_reg;
			opc_lui: if (!inst_q[11]) kind = op_lui;
			opc_load: if (funct3 == 3'b010 && !inst_q[11] && !inst_q[19]) kind = op_load;
			opc_store: if (funct3 == 3'b010 && !inst_q[19] && !inst_q[24]) kind = op_store;
			opc_branch: if (funct3[2:1] == 2'b00 && !inst_q[19] && !inst_q[24]) kind = op_branch;
			opc_jal: if (!inst_q[11]) kind = op_jal;
			opc_system: if (inst_q == 32'h0010_0073) kind = op_halt; // ebreak.
			default: kind = op_illegal;
		endcase
	end

	// ####################
	// ALU and next PC
	// ####################

	assign alu_b = (kind == op_alu_reg) ? rs2_data : imm_i;

	always_comb begin
		case (funct3)
			3'b000:  alu_out = (kind == op_alu_reg && funct7[5]) ? rs1_data - alu_b : rs1_data + alu_b;
			3'b010:  alu_out = {31'b0, $signed(rs1_data) < $signed(alu_b)};
			3'b100:  alu_out = rs1_data ^ alu_b;
			3'b110:  alu_out = rs1_data | alu_b;
			3'b111:  alu_out = rs1_data & alu_b;
			default: alu_out = rs1_data + alu_b;
		endcase
	end

	assign pc_plus4    = pc_q + 32'd4;
	assign take_branch = (rs1_data == rs2_data) ^ funct3[0]; // beq or bne.
	assign next_pc     = (kind == op_jal) ? pc_q + imm_j :
		(kind == op_branch && take_branch) ? pc_q + imm_b : pc_plus4;

	assign wb_data = (state == exec_mem) ? load_data :
		(kind == op_lui) ? imm_u :
		(kind == op_jal) ? pc_plus4 : alu_out;

	assign run    = state == exec_run;
	assign is_mem = kind == op_load || kind == op_store;

	assign mem_start = run && is_mem;
	assign retire    = (run && (kind inside {op_alu_imm, op_alu_reg, op_lui, op_branch, op_jal})) ||
		(state == exec_mem && mem_done);
	assign reg_wen   = (run && (kind inside {op_alu_imm, op_alu_reg, op_lui, op_jal})) ||
		(state == exec_mem && mem_done && kind == op_load);
	assign halted    = state == exec_halt;

	assign mem_op.addr  = rs1_data + ((kind == op_store) ? imm_s : imm_i);
	assign mem_op.wdata = rs2_data;
	assign mem_op.wstrb = {4{kind == op_store}};
	assign mem_op.write = kind == op_store;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= exec_idle;
		end else begin
			case (state)
				exec_idle: if (inst_valid) state <= exec_run;
				exec_run: begin
					if (is_mem) state <= exec_mem;
					else if (kind == op_halt || kind == op_illegal) state <= exec_halt;
					else state <= exec_idle;
				end
				exec_mem: if (mem_done) state <= exec_idle;
				default: state <= exec_halt; // Halted for good.
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			inst_q <= inst;
			pc_q   <= pc;
		end
	end

	// A completion only arrives while a memory operation waits on it.
	a_done_when_pending: assert property (@(posedge clock) disable iff (rst)
		mem_done |-> state == exec_mem);

endmodule

// File: core/rv_lsu.sv
module rv_lsu (
	input  logic             clock,
	input  logic             rst,
	input  logic             mem_start,
	input  rv_pkg::bus_req_t mem_op,
	output logic             lsu_req_valid,
	output rv_pkg::bus_req_t lsu_req,
	input  logic             lsu_resp_valid,
	input  rv_pkg::word_t    lsu_rdata,
	output logic             mem_done,
	output rv_pkg::word_t    load_data
);
	import rv_pkg::*;

	lsu_state_t state;
	bus_req_t   op_q;

	assign lsu_req_valid = state == lsu_issue;
	assign lsu_req       = op_q;
	assign mem_done      = (state == lsu_wait) && lsu_resp_valid; // Store ack too.
	assign load_data     = lsu_rdata;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= lsu_idle;
		end else begin
			case (state)
				lsu_idle:  if (mem_start) state <= lsu_issue;
				lsu_issue: state <= lsu_wait;
				lsu_wait:  if (lsu_resp_valid) state <= lsu_idle;
				default:   state <= lsu_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (mem_start) op_q <= mem_op;
	end

	// ####################
	// Checks
	// ####################

	a_start_when_idle: assert property (@(posedge clock) disable iff (rst)
		mem_start |-> state == lsu_idle);

endmodule

// File: hdl/bus_arbiter.sv
module bus_arbiter (
	input  logic             clock,
	input  logic             rst,
	input  logic             fetch_req_valid,
	input  rv_pkg::word_t    fetch_addr,
	output logic             fetch_resp_valid,
	output rv_pkg::word_t    fetch_rdata,
	input  logic             lsu_req_valid,
	input  rv_pkg::bus_req_t lsu_req,
	output logic             lsu_resp_valid,
	output rv_pkg::word_t    lsu_rdata,
	output logic             mem_req_valid,
	output rv_pkg::bus_req_t mem_req,
	input  logic             mem_resp_valid,
	input  rv_pkg::word_t    mem_rdata,
	output logic             clint_req_valid,
	input  logic             clint_resp_valid,
	input  rv_pkg::word_t    clint_rdata
);
	import rv_pkg::*;

	bus_req_t req;
	logic     req_any;
	logic     hit_clint;
	logic     busy_q, owner_lsu_q, target_clint_q;
	logic     resp_valid;
	word_t    resp_data;

	assign req_any   = fetch_req_valid || lsu_req_valid;
	assign req       = lsu_req_valid ? lsu_req : '{addr: fetch_addr, wdata: '0, wstrb: '0, write: 1'b0};
	assign hit_clint = req.addr == clint_base;

	assign mem_req_valid   = req_any && !hit_clint;
	assign mem_req         = req;
	assign clint_req_valid = req_any && hit_clint;

	assign resp_valid = busy_q && (target_clint_q ? clint_resp_valid : mem_resp_valid);
	assign resp_data  = target_clint_q ? clint_rdata : mem_rdata;

	assign fetch_resp_valid = resp_valid && !owner_lsu_q;
	assign lsu_resp_valid   = resp_valid && owner_lsu_q;
	assign fetch_rdata      = resp_data;
	assign lsu_rdata        = resp_data;

	// Owner and target held until the single response returns.
	always_ff @(posedge clock) begin
		if (rst) begin
			busy_q         <= 1'b0;
			owner_lsu_q    <= 1'b0;
			target_clint_q <= 1'b0;
		end else if (req_any) begin
			busy_q         <= 1'b1;
			owner_lsu_q    <= lsu_req_valid;
			target_clint_q <= hit_clint;
		end else if (resp_valid) begin
			busy_q <= 1'b0;
		end
	end

	a_one_requester: assert property (@(posedge clock) disable iff (rst)
		!(fetch_req_valid && lsu_req_valid));

endmodule

// File: hdl/clint_timer.sv
module clint_timer #(
	parameter int unsigned mtime_step = 1
) (
	input  logic          clock,
	input  logic          rst,
	input  logic          req_valid,
	output logic          resp_valid,
	output rv_pkg::word_t rdata
);
	import rv_pkg::*;

	word_t mtime;

	always_ff @(posedge clock) begin
		if (rst) begin
			mtime      <= '0;
			resp_valid <= 1'b0;
		end else begin
			mtime      <= mtime + word_t'(mtime_step);
			resp_valid <= req_valid; // Answer one cycle later.
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid) rdata <= mtime;
	end

endmodule

// File: hdl/rv_core_top.sv
module rv_core_top #(
	parameter int unsigned mtime_step = 1,
	parameter int          num_regs   = 16
) (
	input  logic             clock,
	input  logic             rst,
	output logic             mem_req_valid,
	output rv_pkg::bus_req_t mem_req,
	input  logic             mem_resp_valid,
	input  rv_pkg::word_t    mem_rdata,
	output logic             halted
);
	import rv_pkg::*;

	logic      fetch_req_valid, fetch_resp_valid;
	word_t     fetch_addr, fetch_rdata;
	logic      inst_valid, retire;
	word_t     inst, pc, next_pc;
	reg_addr_t rs1, rs2, rd;
	word_t     rs1_data, rs2_data, wb_data;
	logic      reg_wen;
	logic      mem_start, mem_done;
	bus_req_t  mem_op;
	word_t     load_data;
	logic      lsu_req_valid, lsu_resp_valid;
	bus_req_t  lsu_req;
	word_t     lsu_rdata;
	logic      clint_req_valid, clint_resp_valid;
	word_t     clint_rdata;

	rv_fetch fetch_i (.clock(clock), .rst(rst), .retire(retire), .next_pc(next_pc),
		.halted(halted), .fetch_req_valid(fetch_req_valid), .fetch_addr(fetch_addr),
		.fetch_resp_valid(fetch_resp_valid), .fetch_data(fetch_rdata),
		.inst_valid(inst_valid), .inst(inst), .pc(pc));

	rv_execute execute_i (.clock(clock), .rst(rst), .inst_valid(inst_valid), .inst(inst),
		.pc(pc), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.reg_wen(reg_wen), .rd(rd), .wb_data(wb_data), .mem_start(mem_start),
		.mem_op(mem_op), .mem_done(mem_done), .load_data(load_data), .retire(retire),
		.next_pc(next_pc), .halted(halted));

	rv_lsu lsu_i (.clock(clock), .rst(rst), .mem_start(mem_start), .mem_op(mem_op),
		.lsu_req_valid(lsu_req_valid), .lsu_req(lsu_req), .lsu_resp_valid(lsu_resp_valid),
		.lsu_rdata(lsu_rdata), .mem_done(mem_done), .load_data(load_data));

	rv_regfile #(.num_regs(num_regs)) regfile_i (.clock(clock), .rst(rst),
		.raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data),
		.wen(reg_wen), .waddr(rd), .wdata(wb_data));

	bus_arbiter arbiter_i (.clock(clock), .rst(rst),
		.fetch_req_valid(fetch_req_valid), .fetch_addr(fetch_addr),
		.fetch_resp_valid(fetch_resp_valid), .fetch_rdata(fetch_rdata),
		.lsu_req_valid(lsu_req_valid), .lsu_req(lsu_req),
		.lsu_resp_valid(lsu_resp_valid), .lsu_rdata(lsu_rdata),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req),
		.mem_resp_valid(mem_resp_valid), .mem_rdata(mem_rdata),
		.clint_req_valid(clint_req_valid), .clint_resp_valid(clint_resp_valid),
		.clint_rdata(clint_rdata));

	clint_timer #(.mtime_step(mtime_step)) clint_i (.clock(clock), .rst(rst),
		.req_valid(clint_req_valid), .resp_valid(clint_resp_valid), .rdata(clint_rdata));

endmodule

// File: bench/tb_program.svh
`ifndef tb_program_svh
`define tb_program_svh

// ####################
// Instruction encoders
// ####################

function automatic word_t itype(int imm, int rs1, int f3, int rd, logic [6:0] opc);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic word_t rtype(int f7, int rs2, int rs1, int f3, int rd);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic word_t stype(int imm, int rs2, int rs1);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t btype(int imm, int rs2, int rs1, int f3);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t utype(int imm, int rd);
	return {imm[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic word_t jtype(int imm, int rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// ####################
// Program and stores
// ####################

localparam int prog_len = 36;

localparam word_t prog_image [prog_len] = '{
	utype(32'h12345, 1), itype(100, 0, 0, 2, opc_op_imm), itype(-7, 0, 0, 3, opc_op_imm),
	rtype(0, 3, 2, 0, 4), rtype(32, 3, 2, 0, 5), rtype(0, 3, 2, 7, 6),  // add, sub, and.
	rtype(0, 2, 1, 6, 7), rtype(0, 3, 2, 4, 8), rtype(0, 2, 3, 2, 9),   // or, xor, slt.
	itype(5, 2, 0, 0, opc_op_imm),                                       // Write to x0.
	stype(256, 1, 0), stype(260, 4, 0), stype(264, 5, 0), stype(268, 6, 0),
	stype(272, 7, 0), stype(276, 8, 0), stype(280, 9, 0), stype(284, 0, 0),
	itype(272, 0, 2, 11, opc_load), stype(288, 11, 0),                   // Copy 0x110 to 0x120.
	btype(8, 2, 2, 0), stype(292, 2, 0),                                 // Taken beq.
	btype(8, 2, 2, 1), itype(55, 0, 0, 12, opc_op_imm), stype(296, 12, 0),
	jtype(12, 13), stype(300, 2, 0), stype(304, 2, 0), stype(308, 13, 0),
	utype(32'h0200c, 14), itype(-8, 14, 0, 14, opc_op_imm),             // x14 = mtime address.
	itype(0, 14, 2, 15, opc_load), stype(312, 15, 0),
	itype(0, 14, 2, 15, opc_load), stype(316, 15, 0),
	32'h0010_0073                                                        // ebreak.
};

localparam int exp_stores = 13;

// One word per slot from 0x100 up. Kind 0 is an exact value, 1 is jumped over, 2 is mtime.
localparam word_t exp_data [16] = '{
	32'h1234_5000, 32'h0000_005d, 32'h0000_006b, 32'h0000_0060,
	32'h1234_5064, 32'hffff_ff9d, 32'h0000_0001, 32'h0000_0000,
	32'h1234_5064, 32'h0000_0000, 32'h0000_0037, 32'h0000_0000,
	32'h0000_0000, 32'h0000_0068, 32'h0000_0000, 32'h0000_0000
};

localparam int exp_kind [16] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 1, 0, 2, 2};

`endif

// File: bench/tb_rv_core.sv
module tb_rv_core;
	import rv_pkg::*;

	localparam int period = 20;

	logic     clock = 1'b0;
	logic     rst = 1'b1;
	logic     mem_req_valid;
	bus_req_t mem_req;
	logic     mem_resp_valid = 1'b0;
	word_t    mem_rdata = '0;
	logic     halted;

	`include "tb_program.svh"

	word_t       mem [256];
	int unsigned seed = 51;
	int          value_errors = 0;
	int          protocol_errors = 0;
	int          stores = 0;
	int          wait_left = 0;
	logic        busy = 1'b0;
	logic        seen_req = 1'b0;
	logic        halt_seen = 1'b0;
	logic        in_reset, req_seen, resp_seen;
	bus_req_t    req_q;
	word_t       resp_word = '0;
	word_t       copy_src = '0;
	word_t       clint_first = '0;
	logic        table_write;
	logic [3:0]  slot;

	rv_core_top #(.mtime_step(1), .num_regs(16)) dut_i (.clock(clock), .rst(rst),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_resp_valid(mem_resp_valid),
		.mem_rdata(mem_rdata), .halted(halted));

	always #(period / 2) clock = ~clock;

	function automatic int next_latency();
		seed = seed * 32'd1103515245 + 32'd12345;
		return int'((seed >> 16) % 4) + 1; // 1 to 4 cycles.
	endfunction

	task automatic value_error(string what, word_t got, word_t want);
		value_errors++;
		$display("Error at %0t: %s, got %h, reference %h", $time, what, got, want);
	endtask

	task automatic protocol_error(string what);
		protocol_errors++;
		$display("At time %0t %s", $time, what);
	endtask

	// ####################
	// Memory model
	// ####################

	always @(posedge clock) begin
		in_reset  = rst;
		req_seen  = mem_req_valid && !rst;
		resp_seen = mem_resp_valid;
		req_q     = mem_req;
		#1;
		halt_seen = halted;
		if (in_reset) begin
			busy = 1'b0;
		end else begin
			if (resp_seen) busy = 1'b0;
			else if (busy) wait_left--;
			if (req_seen) begin
				seen_req  = 1'b1;
				busy      = 1'b1;
				wait_left = next_latency();
				resp_word = mem[req_q.addr[9:2]];
				if (req_q.write) begin
					mem[req_q.addr[9:2]] = req_q.wdata;
					stores++;
					if (req_q.addr == 32'h110) copy_src = req_q.wdata;
					if (req_q.addr == 32'h138) clint_first = req_q.wdata; // First mtime read.
				end
			end
		end
		mem_resp_valid = busy && wait_left == 1;
		mem_rdata      = resp_word;
	end

	// ####################
	// Checks
	// ####################

	assign table_write = mem_req_valid && mem_req.write && mem_req.addr[31:6] == 26'h4;
	assign slot        = mem_req.addr[5:2];

	a_reset_quiet: assert property (@(posedge clock) $past(rst) && rst |-> !mem_req_valid && !halted)
		else protocol_error("a request or halt appeared during reset");

	a_first_fetch: assert property (@(posedge clock) disable iff (rst)
		mem_req_valid && !seen_req |-> mem_req.addr == reset_pc && !mem_req.write)
		else value_error("first request address", $sampled(mem_req.addr), reset_pc);

	a_word_strobe: assert property (@(posedge clock) disable iff (rst)
		mem_req_valid |-> mem_req.wstrb == (mem_req.write ? 4'hf : 4'h0))
		else value_error("write strobe", word_t'($sampled(mem_req.wstrb)),
			$sampled(mem_req.write) ? 32'hf : 32'h0);

	a_store_value: assert property (@(posedge clock) disable iff (rst)
		table_write && exp_kind[slot] == 0 |-> mem_req.wdata == exp_data[slot])
		else value_error("store data", $sampled(mem_req.wdata), exp_data[$sampled(slot)]);

	a_skipped: assert property (@(posedge clock) disable iff (rst)
		table_write |-> exp_kind[slot] != 1)
		else protocol_error("a store reached an address that a branch or jump skips");

	a_copy: assert property (@(posedge clock) disable iff (rst)
		table_write && slot == 4'd8 |-> mem_req.wdata == copy_src)
		else value_error("copied word", $sampled(mem_req.wdata), copy_src);

	a_mtime_rises: assert property (@(posedge clock) disable iff (rst)
		table_write && slot == 4'd15 |-> mem_req.wdata > clint_first)
		else value_error("second mtime read not above first", $sampled(mem_req.wdata), clint_first);

	a_no_clint_on_bus: assert property (@(posedge clock) disable iff (rst)
		mem_req_valid |-> mem_req.addr != clint_base)
		else protocol_error("a CLINT access leaked onto the memory port");

	a_one_outstanding: assert property (@(posedge clock) disable iff (rst)
		mem_req_valid |-> !busy || mem_resp_valid)
		else protocol_error("a request was issued while a response was outstanding");

	a_halt_holds: assert property (@(posedge clock) disable iff (rst)
		halt_seen |-> halted && !mem_req_valid)
		else protocol_error("the core left halt or issued a request after ebreak");

	initial begin
		for (int i = 0; i < 256; i++) mem[i] = 32'h5a5a_0000 ^ word_t'(i << 2);
		for (int i = 0; i < prog_len; i++) mem[i] = prog_image[i];
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;
		wait (halted);
		repeat (10) @(posedge clock); // Bus must stay quiet after halt.
		if (stores != exp_stores) begin
			value_error("store count", word_t'(stores), word_t'(exp_stores));
		end
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog limit from 40 cycles per instruction at the 4-cycle worst case.
	initial begin
		#(prog_len * 40 * 4 * period);
		$display("Watchdog expired before the core halted");
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+bench
common/rv_pkg.sv
core/rv_regfile.sv
core/rv_fetch.sv
core/rv_execute.sv
core/rv_lsu.sv
hdl/bus_arbiter.sv
hdl/clint_timer.sv
hdl/rv_core_top.sv
bench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0
